// File: Bender.yml
package:
  name: rom_stream

sources:
  - common/rom_stream_pkg.sv
  - wb_rom/wb_rom.sv
  - hdl/wb_fetch_master.sv
  - hdl/stream_fifo.sv
  - hdl/word_sink.sv
  - hdl/rom_stream_top.sv
  - target: test
    files:
      - testbench/tb_clkgen.sv
      - testbench/rom_stream_checker.sv
      - testbench/rom_stream_tb.sv

// File: common/rom_stream_pkg.sv
// ----------------------------------------
// Shared types and default sizes for the ROM stream
// Wishbone is 32-bit classic, reads only, sel all ones
// ----------------------------------------
`default_nettype none

package rom_stream_pkg;

  // Sizes
  localparam int ROM_WORDS_DEF  = 32;
  localparam int FIFO_DEPTH_DEF = 4;

  typedef logic [31:0] word_t;
  typedef logic [31:0] wb_adr_t;

  // Request taken with start_i, base is a word address
  typedef struct packed {
    logic [31:0] base;
    logic [15:0] len;
  } fetch_req_t;

  // Master to slave
  typedef struct packed {
    wb_adr_t    adr;
    logic [3:0] sel;
    logic       we;
    logic       cyc;
    logic       stb;
  } wb_m2s_t;

  // Slave to master
  typedef struct packed {
    word_t dat;
    logic  ack;
    logic  err;
  } wb_s2m_t;

  // FIFO payload, err items are always last too
  typedef struct packed {
    word_t data;
    logic  last;
    logic  err;
  } stream_item_t;

endpackage

`default_nettype wire

// File: hdl/rom_stream_top.sv
// ----------------------------------------
// ROM to consumer streaming, one request at a time
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rom_stream_top #(
  parameter int ROM_WORDS  = rom_stream_pkg::ROM_WORDS_DEF,
  parameter int FIFO_DEPTH = rom_stream_pkg::FIFO_DEPTH_DEF
) (
  input  wire                             wb_clk_i,
  input  wire                             wb_rst_i,
  input  wire                             start_i,
  input  wire rom_stream_pkg::fetch_req_t req_i,
  input  wire                             hold_i,
  output logic                            busy_o,
  output rom_stream_pkg::word_t           word_o,
  output logic                            word_vld_o,
  output logic                            done_o,
  output rom_stream_pkg::word_t           sum_o,
  output logic                            err_o
);

  // Bus between fetch engine and ROM
  rom_stream_pkg::wb_m2s_t wb_m2s;
  rom_stream_pkg::wb_s2m_t wb_s2m;

  // FIFO side
  rom_stream_pkg::stream_item_t push_item;
  rom_stream_pkg::stream_item_t pop_item;
  logic push;
  logic pop;
  logic full;
  logic empty;

  // ----------------------------------------
  // Producer
  // ----------------------------------------
  wb_fetch_master fetch_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .start_i     (start_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .wb_m2s_o    (wb_m2s),
    .wb_s2m_i    (wb_s2m),
    .full_i      (full),
    .push_o      (push),
    .push_item_o (push_item)
  );

  wb_rom #(
    .ROM_WORDS (ROM_WORDS)
  ) rom_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_m2s_i (wb_m2s),
    .wb_s2m_o (wb_s2m)
  );

  // Buffer
  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .push_i      (push),
    .push_item_i (push_item),
    .pop_i       (pop),
    .pop_item_o  (pop_item),
    .full_o      (full),
    .empty_o     (empty)
  );

  // Consumer
  word_sink sink_i (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .empty_i    (empty),
    .pop_o      (pop),
    .pop_item_i (pop_item),
    .hold_i     (hold_i),
    .word_o     (word_o),
    .word_vld_o (word_vld_o),
    .done_o     (done_o),
    .sum_o      (sum_o),
    .err_o      (err_o)
  );

endmodule

`default_nettype wire

// File: hdl/stream_fifo.sv
// ----------------------------------------
// FIFO_DEPTH must be a power of two
// No push when full, no pop when empty
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire                               wb_clk_i,
  input  wire                               wb_rst_i,
  input  wire                               push_i,
  input  wire rom_stream_pkg::stream_item_t push_item_i,
  input  wire                               pop_i,
  output rom_stream_pkg::stream_item_t      pop_item_o,
  output logic                              full_o,
  output logic                              empty_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  rom_stream_pkg::stream_item_t mem [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;

  // Storage
  always_ff @(posedge wb_clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_item_i;
    end
  end

  // Pointers wrap on their own
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head item is always visible
  assign pop_item_o = mem[rd_ptr];
  assign full_o     = (count == FIFO_DEPTH);
  assign empty_o    = (count == '0);

endmodule

`default_nettype wire

// File: hdl/wb_fetch_master.sv
// ----------------------------------------
// One Wishbone read per word, len of zero unsupported
// Strobe starts only when the FIFO has room
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module wb_fetch_master (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          start_i,
  input  wire rom_stream_pkg::fetch_req_t req_i,
  output logic                         busy_o,
  output rom_stream_pkg::wb_m2s_t      wb_m2s_o,
  input  wire rom_stream_pkg::wb_s2m_t wb_s2m_i,
  input  wire                          full_i,
  output logic                         push_o,
  output rom_stream_pkg::stream_item_t push_item_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_t;

  state_t      state;
  logic [31:0] addr;
  logic [15:0] remain;
  logic        resp;
  logic        final_wd;

  // Slave answered this cycle
  assign resp     = (state == ST_WAIT) & (wb_s2m_i.ack | wb_s2m_i.err);
  assign final_wd = (remain == 16'd1);

  // ----------------------------------------
  // Control FSM and counters
  // ----------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state  <= ST_IDLE;
      addr   <= '0;
      remain <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Requests while busy are dropped
          if (start_i) begin
            addr   <= req_i.base;
            remain <= req_i.len;
            state  <= ST_REQ;
          end
        end
        ST_REQ: begin
          // Hold off the strobe while full
          if (!full_i) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (resp) begin
            if (wb_s2m_i.err || final_wd) begin
              state <= ST_IDLE;
            end else begin
              addr   <= addr + 32'd1;
              remain <= remain - 16'd1;
              state  <= ST_REQ;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign busy_o = (state != ST_IDLE);

  // Bus side, stb drops after the ack cycle
  assign wb_m2s_o.adr = {addr[29:0], 2'b00};
  assign wb_m2s_o.sel = 4'hf;
  assign wb_m2s_o.we  = 1'b0;
  assign wb_m2s_o.cyc = (state == ST_WAIT);
  assign wb_m2s_o.stb = (state == ST_WAIT);

  // Push in the response cycle
  // Bus error closes the request with an empty item
  assign push_o           = resp;
  assign push_item_o.data = wb_s2m_i.err ? '0 : wb_s2m_i.dat;
  assign push_item_o.last = wb_s2m_i.err | final_wd;
  assign push_item_o.err  = wb_s2m_i.err;

endmodule

`default_nettype wire

// File: hdl/word_sink.sv
// ----------------------------------------
// Pops one item per cycle unless hold_i is set
// Outputs come one cycle after the pop
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module word_sink (
  input  wire                               wb_clk_i,
  input  wire                               wb_rst_i,
  input  wire                               empty_i,
  output logic                              pop_o,
  input  wire rom_stream_pkg::stream_item_t pop_item_i,
  input  wire                               hold_i,
  output rom_stream_pkg::word_t             word_o,
  output logic                              word_vld_o,
  output logic                              done_o,
  output rom_stream_pkg::word_t             sum_o,
  output logic                              err_o
);

  rom_stream_pkg::word_t acc;
  rom_stream_pkg::word_t acc_nxt;

  assign pop_o = ~empty_i & ~hold_i;

  // Error items carry no data for the checksum
  assign acc_nxt = pop_item_i.err ? acc : (acc ^ pop_item_i.data);

  // Word path
  always_ff @(posedge wb_clk_i) begin
    if (pop_o) begin
      word_o <= pop_item_i.data;
    end
  end

  // ----------------------------------------
  // Strobes, checksum and request close
  // ----------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      word_vld_o <= 1'b0;
      done_o     <= 1'b0;
      err_o      <= 1'b0;
      acc        <= '0;
    end else begin
      word_vld_o <= pop_o & ~pop_item_i.err;
      done_o     <= pop_o & pop_item_i.last;
      if (pop_o) begin
        if (pop_item_i.last) begin
          // Checksum restarts for the next request
          acc   <= '0;
          err_o <= pop_item_i.err;
        end else begin
          acc <= acc_nxt;
        end
      end
    end
  end

  // Sum captured together with done
  always_ff @(posedge wb_clk_i) begin
    if (pop_o && pop_item_i.last) begin
      sum_o <= acc_nxt;
    end
  end

endmodule

`default_nettype wire

// File: testbench/rom_stream_checker.sv
// ----------------------------------------
// Bound to stream_fifo and to wb_rom
// Ports a target lacks are tied low there
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rom_stream_checker (
  input wire                          clk_i,
  input wire                          rst_i,
  input wire                          push_i,
  input wire                          pop_i,
  input wire                          full_i,
  input wire                          empty_i,
  input wire rom_stream_pkg::wb_m2s_t wb_m2s_i,
  input wire rom_stream_pkg::wb_s2m_t wb_s2m_i
);

  // Number of failed assertions, read by the testbench
  int fail_cnt = 0;

  // ----------------------------------------
  // FIFO rules
  // ----------------------------------------
  push_not_full: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("push while FIFO full");
    end

  pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pop while FIFO empty");
    end

  // ----------------------------------------
  // Wishbone rules
  // ----------------------------------------
  ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(wb_s2m_i.ack && wb_s2m_i.err))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack and err in the same cycle");
    end

  // Registered ack answers the strobe of the cycle before
  ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_s2m_i.ack |-> $past(wb_m2s_i.cyc && wb_m2s_i.stb))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack without a preceding strobe");
    end

  // Open strobe keeps stb high and the address still
  adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (wb_m2s_i.stb && !wb_s2m_i.ack && !wb_s2m_i.err)
      |=> (wb_m2s_i.stb && $stable(wb_m2s_i.adr)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("address or strobe changed before the response");
    end

endmodule

bind stream_fifo rom_stream_checker chk_fifo_i (
  .clk_i    (wb_clk_i),
  .rst_i    (wb_rst_i),
  .push_i   (push_i),
  .pop_i    (pop_i),
  .full_i   (full_o),
  .empty_i  (empty_o),
  .wb_m2s_i ('0),
  .wb_s2m_i ('0)
);

bind wb_rom rom_stream_checker chk_wb_i (
  .clk_i    (wb_clk_i),
  .rst_i    (wb_rst_i),
  .push_i   (1'b0),
  .pop_i    (1'b0),
  .full_i   (1'b0),
  .empty_i  (1'b0),
  .wb_m2s_i (wb_m2s_i),
  .wb_s2m_i (wb_s2m_o)
);

`default_nettype wire

// File: testbench/rom_stream_tb.sv
// ----------------------------------------
// Random requests and hold_i checked against a ROM model
// Requests past ROM_WORDS must close with err_o set
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rom_stream_tb;

  localparam int ROM_WORDS = rom_stream_pkg::ROM_WORDS_DEF;
  localparam int NUM_REQ   = 40;
  localparam int WAIT_MAX  = 2000;

  logic                       wb_clk;
  logic                       wb_rst;
  logic                       start;
  rom_stream_pkg::fetch_req_t req;
  logic                       hold;
  logic                       busy;
  rom_stream_pkg::word_t      word;
  logic                       word_vld;
  logic                       done;
  rom_stream_pkg::word_t      sum;
  logic                       err;

  // Reference model and expected results in order
  rom_stream_pkg::word_t model_mem [ROM_WORDS];
  rom_stream_pkg::word_t exp_words [$];
  rom_stream_pkg::word_t exp_sums [$];
  logic                  exp_errs [$];

  logic [31:0] rng;
  int          hold_run = 0;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          timeout_cnt = 0;
  int          done_cnt = 0;
  int          accepted = 0;
  int          assert_cnt;

  tb_clkgen clkgen_i (
    .clk_o (wb_clk)
  );

  rom_stream_top dut_i (
    .wb_clk_i   (wb_clk),
    .wb_rst_i   (wb_rst),
    .start_i    (start),
    .req_i      (req),
    .hold_i     (hold),
    .busy_o     (busy),
    .word_o     (word),
    .word_vld_o (word_vld),
    .done_o     (done),
    .sum_o      (sum),
    .err_o      (err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ----------------------------------------
  // Compare tasks and failure reports
  // ----------------------------------------
  task automatic check_word(input rom_stream_pkg::word_t got, input rom_stream_pkg::word_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: word_o is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_sum(input rom_stream_pkg::word_t got, input rom_stream_pkg::word_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: sum_o is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: err_o is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    other_cnt++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("timeout while waiting for %s at %0t", what, $time);
  endtask

  // One clock, then new hold_i with occasional long runs
  task automatic next_cycle();
    @(posedge wb_clk);
    #1;
    if (hold_run > 0) begin
      hold = 1'b1;
      hold_run--;
    end else begin
      rng = xorshift32(rng);
      if (rng[3:0] == 4'd0) begin
        hold_run = 8 + int'(rng[8:4]);
        hold     = 1'b1;
      end else begin
        hold = rng[5] & rng[6];
      end
    end
  endtask

  // Base 0..39, len 1..12
  task automatic random_req(output rom_stream_pkg::fetch_req_t r);
    rng = xorshift32(rng);
    r.base = 32'(rng % 40);
    r.len  = 16'(1 + (rng >> 8) % 12);
  endtask

  // Words up to the first address past the ROM, then sum and err
  task automatic build_expect(input rom_stream_pkg::fetch_req_t r);
    rom_stream_pkg::word_t acc;
    logic                  bad;
    int unsigned           a;
    acc = '0;
    bad = 1'b0;
    for (int i = 0; i < r.len && !bad; i++) begin
      a = r.base + i;
      if (a >= ROM_WORDS) begin
        bad = 1'b1;
      end else begin
        exp_words.push_back(model_mem[a]);
        acc = acc ^ model_mem[a];
      end
    end
    exp_sums.push_back(acc);
    exp_errs.push_back(bad);
  endtask

  // ----------------------------------------
  // Output monitor, mid-cycle sampling
  // ----------------------------------------
  always @(negedge wb_clk) begin
    if (!wb_rst && word_vld === 1'b1) begin
      if (exp_words.size() == 0) begin
        report_failure("word_vld_o strobe with no word expected");
      end else begin
        check_word(word, exp_words.pop_front());
      end
    end
    if (!wb_rst && done === 1'b1) begin
      done_cnt++;
      if (exp_sums.size() == 0) begin
        report_failure("done_o with no request open");
      end else begin
        check_sum(sum, exp_sums.pop_front());
        check_err(err, exp_errs.pop_front());
      end
    end
  end

  initial begin
    int                         cnt;
    rom_stream_pkg::fetch_req_t r;
    wb_rst = 1'b1;
    start  = 1'b0;
    req    = '0;
    hold   = 1'b0;
    rng    = 32'hf780;
    $readmemh("wb_rom/rom_image.hex", model_mem);
    repeat (16) @(posedge wb_clk);
    #1;
    wb_rst = 1'b0;

    // Quiet outputs until the first request
    for (int i = 0; i < 12; i++) begin
      next_cycle();
      if (busy !== 1'b0 || word_vld !== 1'b0 || done !== 1'b0) begin
        report_failure("outputs active before the first start_i");
      end
    end

    // Each pass starts with the fetch engine idle
    for (int n = 0; n < NUM_REQ && timeout_cnt == 0; n++) begin
      random_req(r);
      build_expect(r);
      accepted++;
      start = 1'b1;
      req   = r;
      next_cycle();
      start = 1'b0;
      if (busy !== 1'b1) report_failure("busy_o did not rise after start_i");
      // Stray starts while busy must be dropped
      cnt = 0;
      while (busy && cnt < WAIT_MAX) begin
        rng = xorshift32(rng);
        if (rng[2:0] == 3'd0) begin
          random_req(r);
          start = 1'b1;
          req   = r;
        end
        next_cycle();
        start = 1'b0;
        cnt++;
      end
      if (cnt >= WAIT_MAX) report_timeout("the fetch engine to finish a request");
    end

    // Drain the FIFO and sink
    if (timeout_cnt == 0) begin
      cnt = 0;
      while ((exp_words.size() != 0 || exp_sums.size() != 0) && cnt < WAIT_MAX) begin
        next_cycle();
        cnt++;
      end
      if (cnt >= WAIT_MAX) begin
        report_timeout("the last words and done_o");
      end else begin
        repeat (20) next_cycle();
        if (done_cnt != accepted) report_failure("done_o count differs from accepted requests");
      end
    end

    assert_cnt = dut_i.fifo_i.chk_fifo_i.fail_cnt + dut_i.rom_i.chk_wb_i.fail_cnt;
    $display("errors: %0d mismatch, %0d other, %0d timeout, %0d assertion",
             mismatch_cnt, other_cnt, timeout_cnt, assert_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0 && timeout_cnt == 0 && assert_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clkgen.sv
// ----------------------------------------
// Free-running clock, 100 ns period, starts low
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic clk_o
);

  // Half period of 50 ns
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
common/rom_stream_pkg.sv
wb_rom/wb_rom.sv
hdl/wb_fetch_master.sv
hdl/stream_fifo.sv
hdl/word_sink.sv
hdl/rom_stream_top.sv
testbench/tb_clkgen.sv
testbench/rom_stream_checker.sv
testbench/rom_stream_tb.sv

// File: wb_rom/rom_image.hex
// One 32-bit word per line, word address 0 to 31 from the top
// Bytes are A0+adr, adr, FF-adr, 7*adr
A000FF00
A101FE07
A202FD0E
A303FC15
A404FB1C
A505FA23
A606F92A
A707F831
A808F738
A909F63F
AA0AF546
AB0BF44D
AC0CF354
AD0DF25B
AE0EF162
AF0FF069
B010EF70
B111EE77
B212ED7E
B313EC85
B414EB8C
B515EA93
B616E99A
B717E8A1
B818E7A8
B919E6AF
BA1AE5B6
BB1BE4BD
BC1CE3C4
BD1DE2CB
BE1EE1D2
BF1FE0D9

// File: wb_rom/wb_rom.sv
// ----------------------------------------
// Single classic reads only, data valid with ack
// Writes and addresses past ROM_WORDS get err
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module wb_rom #(
  parameter int ROM_WORDS = 32
) (
  input  wire                     wb_clk_i,
  input  wire                     wb_rst_i,
  input  wire rom_stream_pkg::wb_m2s_t wb_m2s_i,
  output rom_stream_pkg::wb_s2m_t      wb_s2m_o
);

  localparam int AW = $clog2(ROM_WORDS);

  rom_stream_pkg::word_t mem [ROM_WORDS];
  rom_stream_pkg::word_t rd_dat;

  logic [29:0] word_adr;
  logic        in_range;
  logic        bad_acc;
  logic        new_stb;
  logic        ack_q;
  logic        err_q;

  // Contents come from the hex image
  initial begin
    $readmemh("wb_rom/rom_image.hex", mem);
  end

  // Byte address down to word address
  assign word_adr = wb_m2s_i.adr[31:2];
  assign in_range = (word_adr < ROM_WORDS);
  assign bad_acc  = wb_m2s_i.we | ~in_range;

  // Strobe not yet answered
  assign new_stb = wb_m2s_i.cyc & wb_m2s_i.stb & ~ack_q & ~err_q;

  // ----------------------------------------
  // Synchronous read port
  // ----------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_m2s_i.stb && in_range) begin
      rd_dat <= mem[word_adr[AW-1:0]];
    end
  end

  // Registered response, one per strobe
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= new_stb & ~bad_acc;
      err_q <= new_stb & bad_acc;
    end
  end

  assign wb_s2m_o = '{dat: rd_dat, ack: ack_q, err: err_q};

endmodule

`default_nettype wire
